// ==== build.f ====
+incdir+design
design/sim_types_pkg.sv
design/msg_format_pkg.sv
design/monitor_ifs.sv
design/event_decode.sv
design/core_table.sv
design/min_time_tree.sv
design/stall_control.sv
design/core_monitor.sv
bench/core_monitor_tb.sv

// ==== Makefile ====
# Verilator build for the core monitor testbench

VERILATOR ?= verilator
TOP       ?= core_monitor_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -j 0
SOURCES   := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/core_monitor_tb.sv ====
// testbench of the core monitor
// clock, reset, directed and random bus traffic, table and stall model
// concurrent assertions on stall, watchdog

`timescale 1ns/1ns

`include "monitor_config.svh"

module core_monitor_tb;

   localparam int CLK_PERIOD = 4;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_CORE = `MON_NUM_CORE;
   // decode, table, one level per core-id bit, then the stall register
   localparam int LAT = 2 + sim_types_pkg::CORE_ID_WID;
   localparam int SEED = 5;
   localparam int NUM_RAND = 400;
   // upper bound on the directed part
   localparam int DIRECTED_CYCLES = 48;
   localparam int MARGIN = 40;
   localparam int TIMEOUT_NS =
      (RESET_CYCLES + DIRECTED_CYCLES + NUM_RAND + LAT + 2 + MARGIN) * CLK_PERIOD;

   logic clk;
   logic reset;
   msg_format_pkg::msg_t msg;
   logic sent_msg_vld;
   logic rcv_msg_vld;
   sim_types_pkg::core_id_t core_id;
   sim_types_pkg::core_mask_t stall;

   // reference table and stall vector
   sim_types_pkg::core_mask_t m_active;
   sim_types_pkg::core_mask_t m_stall;
   sim_types_pkg::lp_id_t m_lp [NUM_CORE];
   sim_types_pkg::event_time_t m_time [NUM_CORE];
   int stall_sets;
   int releases;

   // predictions in drive order, head is what stall shows now
   sim_types_pkg::core_mask_t pred_q [$];
   sim_types_pkg::core_mask_t exp_stall;

   core_monitor u_core_monitor (
      .clk          (clk),
      .reset        (reset),
      .msg          (msg),
      .sent_msg_vld (sent_msg_vld),
      .rcv_msg_vld  (rcv_msg_vld),
      .core_id      (core_id),
      .stall        (stall)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // exp_stall only moves on the falling edge
   assert property (@(posedge clk) stall == exp_stall)
      else begin
         $display("Error at %0t ns: stall is %b, model expects %b",
                  $time, $sampled(stall), $sampled(exp_stall));
         $display("Done: errors found");
         $fatal(1, "stall mismatch");
      end

   // nothing may leave the pipeline while reset is high
   assert property (@(posedge clk) reset |-> stall == '0)
      else begin
         $display("Error at %0t ns: stall is %b during reset", $time, $sampled(stall));
         $display("Done: errors found");
         $fatal(1, "stall set in reset");
      end

   function automatic msg_format_pkg::msg_t make_msg(input int lp, input int t,
                                                     input bit end_flag);
      msg_format_pkg::msg_t m;
      m = '0;
      m[msg_format_pkg::END_BIT] = end_flag;
      m[msg_format_pkg::LP_LSB +: sim_types_pkg::LP_ID_WID] = sim_types_pkg::lp_id_t'(lp);
      m[msg_format_pkg::TIME_LSB +: `MON_TIME_WID] = sim_types_pkg::event_time_t'(t);
      return m;
   endfunction

   // conflict if another active core already runs this LP
   task automatic apply_dispatch(input int c, input int lp, input int t);
      bit conflict;
      conflict = 1'b0;
      for (int k = 0; k < NUM_CORE; k++) begin
         if (k != c && m_active[k] && m_lp[k] == sim_types_pkg::lp_id_t'(lp)) begin
            conflict = 1'b1;
         end
      end
      m_stall[c] = conflict;
      if (conflict) begin
         stall_sets++;
      end
      m_active[c] = 1'b1;
      m_lp[c] = sim_types_pkg::lp_id_t'(lp);
      m_time[c] = sim_types_pkg::event_time_t'(t);
   endtask

   // oldest other core on the stored LP is released
   task automatic apply_return(input int c);
      bit found;
      int win;
      found = 1'b0;
      win = 0;
      // ascending scan with strict compare, ties go to the lower index
      for (int k = 0; k < NUM_CORE; k++) begin
         if (k != c && m_active[k] && m_lp[k] == m_lp[c]) begin
            if (!found || m_time[k] < m_time[win]) begin
               win = k;
               found = 1'b1;
            end
         end
      end
      m_active[c] = 1'b0;
      m_stall[c] = 1'b0;
      if (found) begin
         m_stall[win] = 1'b0;
         releases++;
      end
   endtask

   // one clock of bus traffic plus the model step for it
   task automatic drive_cycle(input bit send, input bit rcv, input bit end_flag,
                              input int core, input int lp, input int t);
      @(negedge clk);
      if (!send && !rcv) begin
         // junk on an idle bus must be ignored
         msg = $urandom;
         core_id = sim_types_pkg::core_id_t'($urandom % NUM_CORE);
      end else begin
         msg = make_msg(lp, t, end_flag);
         core_id = sim_types_pkg::core_id_t'(core);
      end
      sent_msg_vld = send;
      rcv_msg_vld = rcv;
      if (send) begin
         apply_dispatch(core, lp, t);
      end else if (rcv && end_flag) begin
         apply_return(core);
      end
      // drive at negedge n shows on stall from posedge n+LAT+1 on
      pred_q.push_back(m_stall);
      if (pred_q.size() > LAT + 1) begin
         exp_stall = pred_q.pop_front();
      end
   endtask

   task automatic dispatch_event(input int core, input int lp, input int t);
      drive_cycle(1'b1, 1'b0, 1'b0, core, lp, t);
   endtask

   // lp and time fields of a return are don't care
   task automatic return_event(input int core, input bit end_flag);
      drive_cycle(1'b0, 1'b1, end_flag, core, $urandom % `MON_NUM_LP, $urandom);
   endtask

   task automatic idle_cycles(input int n);
      for (int i = 0; i < n; i++) begin
         drive_cycle(1'b0, 1'b0, 1'b0, 0, 0, 0);
      end
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
      $display("Done: errors found");
      $fatal(1, "watchdog expired");
   end

   initial begin
      int pick;
      int core;
      int lp;
      int t;
      void'($urandom(SEED));
      reset = 1'b1;
      msg = '0;
      sent_msg_vld = 1'b0;
      rcv_msg_vld = 1'b0;
      core_id = '0;
      m_active = '0;
      m_stall = '0;
      exp_stall = '0;
      stall_sets = 0;
      releases = 0;
      for (int k = 0; k < NUM_CORE; k++) begin
         m_lp[k] = '0;
         m_time[k] = '0;
      end

      idle_cycles(RESET_CYCLES);
      reset = 1'b0;

      // free LPs, then two cores piling onto LP 3
      dispatch_event(0, 3, 100);
      dispatch_event(1, 5, 50);
      dispatch_event(2, 3, 80);
      dispatch_event(3, 3, 80);
      idle_cycles(LAT + 1);

      // equal times on cores 2 and 3, core 2 must go
      return_event(0, 1'b1);
      idle_cycles(LAT + 1);

      // no end flag, core 1 still holds LP 5
      return_event(1, 1'b0);
      dispatch_event(0, 5, 10);
      idle_cycles(LAT + 1);

      return_event(2, 1'b1);
      return_event(1, 1'b1);
      idle_cycles(LAT + 1);

      // smaller time on the higher index wins
      dispatch_event(1, 2, 300);
      dispatch_event(2, 2, 260);
      dispatch_event(3, 2, 200);
      return_event(1, 1'b1);
      idle_cycles(LAT + 1);

      // count only what the random traffic raises and releases
      stall_sets = 0;
      releases = 0;

      // back to back over two LPs, small times for ties
      for (int i = 0; i < NUM_RAND; i++) begin
         pick = $urandom % 8;
         core = $urandom % NUM_CORE;
         lp = $urandom % 2;
         t = $urandom % 16;
         if (pick < 4) begin
            dispatch_event(core, lp, t);
         end else if (pick < 6) begin
            return_event(core, 1'b1);
         end else if (pick == 6) begin
            return_event(core, 1'b0);
         end else begin
            idle_cycles(1);
         end
      end

      // let the last predictions reach the output
      idle_cycles(LAT + 2);

      if (stall_sets == 0 || releases == 0) begin
         $display("random traffic never raised or never released a stall");
         $display("Done: errors found");
         $fatal(1, "stall rules not exercised");
      end else begin
         $display("Done: no errors");
         $finish;
      end
   end

endmodule

// ==== design/core_monitor.sv ====
// top of the core monitor
// decode, table, minimum tree and stall stages in a chain
// plain bus ports in, one stall line per core out

`timescale 1ns/1ns

`include "monitor_config.svh"

module core_monitor (
   input  logic                      clk,
   input  logic                      reset,
   input  msg_format_pkg::msg_t      msg,
   input  logic                      sent_msg_vld,
   input  logic                      rcv_msg_vld,
   input  sim_types_pkg::core_id_t   core_id,
   output sim_types_pkg::core_mask_t stall
);

   // decoded event into the table
   event_if ev_bus ();
   // candidates into the tree
   cand_if tab_cand ();
   // candidates plus winner into the stall stage
   cand_if win_cand ();

   // table timestamps, lined up with tab_cand
   sim_types_pkg::event_time_t snap_times [`MON_NUM_CORE];

   event_decode u_event_decode (
      .clk          (clk),
      .reset        (reset),
      .msg          (msg),
      .sent_msg_vld (sent_msg_vld),
      .rcv_msg_vld  (rcv_msg_vld),
      .core_id      (core_id),
      .ev           (ev_bus.src)
   );

   core_table u_core_table (
      .clk        (clk),
      .reset      (reset),
      .ev         (ev_bus.dst),
      .cand       (tab_cand.src),
      .snap_times (snap_times)
   );

   min_time_tree u_min_time_tree (
      .clk        (clk),
      .reset      (reset),
      .cand_in    (tab_cand.dst),
      .snap_times (snap_times),
      .cand_out   (win_cand.src)
   );

   stall_control u_stall_control (
      .clk   (clk),
      .reset (reset),
      .cand  (win_cand.dst),
      .stall (stall)
   );

endmodule

// ==== design/stall_control.sv ====
// last pipeline stage of the core monitor
// stall register per core, set on conflicting dispatch, released on return

`timescale 1ns/1ns

module stall_control (
   input  logic                      clk,
   input  logic                      reset,
   cand_if.dst                       cand,
   output sim_types_pkg::core_mask_t stall
);

   // one-hot of the origin core and of the winner
   sim_types_pkg::core_mask_t self_bit;
   sim_types_pkg::core_mask_t win_bit;
   sim_types_pkg::core_mask_t set_mask;
   sim_types_pkg::core_mask_t clr_mask;
   logic any_cand;

   assign self_bit = sim_types_pkg::core_mask_t'(1) << cand.core_id;
   assign win_bit = sim_types_pkg::core_mask_t'(1) << cand.win_id;
   assign any_cand = |cand.cand_mask;

   always_comb begin
      set_mask = '0;
      clr_mask = '0;
      case (cand.op)
         msg_format_pkg::op_dispatch: begin
            // LP already running elsewhere, hold this core
            if (any_cand) begin
               set_mask = self_bit;
            end else begin
               clr_mask = self_bit;
            end
         end
         msg_format_pkg::op_return: begin
            // returning core is free, oldest waiter on the LP goes next
            clr_mask = self_bit;
            if (any_cand) begin
               clr_mask = self_bit | win_bit;
            end
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stall <= '0;
      end else begin
         stall <= (stall | set_mask) & ~clr_mask;
      end
   end

endmodule

// ==== design/min_time_tree.sv ====
// pipelined minimum tree of the core monitor
// pairwise compare of masked timestamps, one register level per core-id bit
// op, origin core and mask ride along so several events share the tree

`timescale 1ns/1ns

`include "monitor_config.svh"

module min_time_tree (
   input  logic                       clk,
   input  logic                       reset,
   cand_if.dst                        cand_in,
   input  sim_types_pkg::event_time_t snap_times [`MON_NUM_CORE],
   cand_if.src                        cand_out
);

   localparam int NUM_CORE = `MON_NUM_CORE;
   localparam int LEVELS = sim_types_pkg::CORE_ID_WID;

   // level 0 is the leaves, level LEVELS the root
   for (genvar l = 0; l <= LEVELS; l++) begin : lvl
      localparam int N = NUM_CORE >> l;

      msg_format_pkg::mon_op_t op;
      sim_types_pkg::core_id_t core_id;
      sim_types_pkg::core_mask_t mask;
      sim_types_pkg::core_id_t idx [N];

      if (l == 0) begin : leaf
         assign op = cand_in.op;
         assign core_id = cand_in.core_id;
         assign mask = cand_in.cand_mask;
         for (genvar n = 0; n < N; n++) begin : init
            assign idx[n] = sim_types_pkg::core_id_t'(n);
         end
      end else begin : node
         // leaves covered by one node of the level below
         localparam int HALF = 1 << (l - 1);
         logic [N-1:0] take_r;

         for (genvar n = 0; n < N; n++) begin : cmp
            logic l_vld, r_vld;
            // a node is live if any leaf under it is a candidate
            assign l_vld = |lvl[l-1].mask[2*n*HALF +: HALF];
            assign r_vld = |lvl[l-1].mask[(2*n+1)*HALF +: HALF];
            // strict compare, so a tie keeps the lower index
            assign take_r[n] = r_vld &&
                               (!l_vld || (lvl[l-1].ts.tm[2*n+1] < lvl[l-1].ts.tm[2*n]));
         end

         always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
               op <= msg_format_pkg::op_none;
            end else begin
               op <= lvl[l-1].op;
            end
         end

         always_ff @(posedge clk) begin
            core_id <= lvl[l-1].core_id;
            mask <= lvl[l-1].mask;
            for (int n = 0; n < N; n++) begin
               idx[n] <= take_r[n] ? lvl[l-1].idx[2*n+1] : lvl[l-1].idx[2*n];
            end
         end
      end

      // root keeps only the index
      if (l < LEVELS) begin : ts
         sim_types_pkg::event_time_t tm [N];

         if (l == 0) begin : load
            assign tm = snap_times;
         end else begin : keep
            always_ff @(posedge clk) begin
               for (int n = 0; n < N; n++) begin
                  tm[n] <= node.take_r[n] ? lvl[l-1].ts.tm[2*n+1] : lvl[l-1].ts.tm[2*n];
               end
            end
         end
      end
   end

   assign cand_out.op = lvl[LEVELS].op;
   assign cand_out.core_id = lvl[LEVELS].core_id;
   assign cand_out.cand_mask = lvl[LEVELS].mask;
   assign cand_out.win_id = lvl[LEVELS].idx[0];

endmodule

// ==== design/core_table.sv ====
// second pipeline stage of the core monitor
// per-core table of LP, timestamp and active flag
// candidate mask of conflicting cores, timestamp snapshot for the tree

`timescale 1ns/1ns

`include "monitor_config.svh"

module core_table (
   input  logic                       clk,
   input  logic                       reset,
   event_if.dst                       ev,
   cand_if.src                        cand,
   output sim_types_pkg::event_time_t snap_times [`MON_NUM_CORE]
);

   localparam int NUM_CORE = `MON_NUM_CORE;

   // the table itself
   sim_types_pkg::lp_id_t lp_tab [NUM_CORE];
   sim_types_pkg::event_time_t time_tab [NUM_CORE];
   sim_types_pkg::core_mask_t active;

   // LP the other cores are checked against
   sim_types_pkg::lp_id_t match_lp;
   sim_types_pkg::core_mask_t match;

   // new LP on dispatch, the stored one on return
   assign match_lp = (ev.op == msg_format_pkg::op_dispatch) ? ev.lp_id : lp_tab[ev.core_id];

   // other active cores on that LP, table as it was before this event
   always_comb begin
      for (int m = 0; m < NUM_CORE; m++) begin
         match[m] = active[m] && (lp_tab[m] == match_lp) &&
                    (ev.core_id != sim_types_pkg::core_id_t'(m));
      end
   end

   // table update, one event per cycle in arrival order
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         active <= '0;
         for (int m = 0; m < NUM_CORE; m++) begin
            lp_tab[m] <= '0;
            time_tab[m] <= '0;
         end
      end else begin
         case (ev.op)
            msg_format_pkg::op_dispatch: begin
               // core takes the new event
               active[ev.core_id] <= 1'b1;
               lp_tab[ev.core_id] <= ev.lp_id;
               time_tab[ev.core_id] <= ev.event_time;
            end
            msg_format_pkg::op_return: begin
               // LP and time stay, only the flag drops
               active[ev.core_id] <= 1'b0;
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cand.op <= msg_format_pkg::op_none;
      end else begin
         cand.op <= ev.op;
      end
   end

   // returning core is never a candidate, so the old times are fine
   always_ff @(posedge clk) begin
      cand.core_id <= ev.core_id;
      cand.cand_mask <= match;
      snap_times <= time_tab;
   end

   // winner gets filled in by the tree
   assign cand.win_id = '0;

endmodule

// ==== design/event_decode.sv ====
// first pipeline stage of the core monitor
// samples the bus strobes and fields, classifies the cycle as one operation

`timescale 1ns/1ns

module event_decode (
   input  logic                    clk,
   input  logic                    reset,
   input  msg_format_pkg::msg_t    msg,
   input  logic                    sent_msg_vld,
   input  logic                    rcv_msg_vld,
   input  sim_types_pkg::core_id_t core_id,
   event_if.src                    ev
);

   // end flag marks the last message of a returning event
   logic end_flag;

   assign end_flag = msg[msg_format_pkg::END_BIT];

   // dispatch wins if both strobes ever show up together
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ev.op <= msg_format_pkg::op_none;
      end else if (sent_msg_vld) begin
         ev.op <= msg_format_pkg::op_dispatch;
      end else if (rcv_msg_vld && end_flag) begin
         ev.op <= msg_format_pkg::op_return;
      end else begin
         // return without end flag is dropped here
         ev.op <= msg_format_pkg::op_none;
      end
   end

   // payload, qualified by op downstream
   always_ff @(posedge clk) begin
      ev.core_id <= core_id;
      ev.lp_id <= msg[msg_format_pkg::LP_LSB +: sim_types_pkg::LP_ID_WID];
      ev.event_time <= msg[msg_format_pkg::TIME_LSB +: $bits(sim_types_pkg::event_time_t)];
   end

endmodule

// ==== design/monitor_ifs.sv ====
// stage-to-stage buses of the core monitor
// event_if: decoded event, decode stage to table stage
// cand_if: operation plus candidate mask, table to tree and tree to stall

`timescale 1ns/1ns

interface event_if;

   // fields only mean something while op is not op_none
   msg_format_pkg::mon_op_t op;
   sim_types_pkg::core_id_t core_id;
   sim_types_pkg::lp_id_t lp_id;
   sim_types_pkg::event_time_t event_time;

   modport src (output op, core_id, lp_id, event_time);
   modport dst (input op, core_id, lp_id, event_time);

endinterface

interface cand_if;

   msg_format_pkg::mon_op_t op;
   // core the event came from or went to
   sim_types_pkg::core_id_t core_id;
   // other active cores on the same LP
   sim_types_pkg::core_mask_t cand_mask;
   // smallest-timestamp candidate, valid when cand_mask is non-empty
   sim_types_pkg::core_id_t win_id;

   modport src (output op, core_id, cand_mask, win_id);
   modport dst (input op, core_id, cand_mask, win_id);

endinterface

// ==== design/msg_format_pkg.sv ====
// message bus format of the core monitor
// bus word type, field positions, pipeline operation enum

`include "monitor_config.svh"

package msg_format_pkg;

   // one word on the shared message bus
   typedef logic [`MON_MSG_WID-1:0] msg_t;

   // timestamp in the low bits
   localparam int TIME_LSB = 0;
   // LP id right above the timestamp
   localparam int LP_LSB = TIME_LSB + `MON_TIME_WID;
   // end flag, top bit of the word
   localparam int END_BIT = `MON_MSG_WID - 1;

   // what an event does as it moves down the pipeline
   typedef enum logic [1:0] {
      op_none     = 2'd0,
      op_dispatch = 2'd1,
      op_return   = 2'd2
   } mon_op_t;

endpackage

// ==== design/sim_types_pkg.sv ====
// simulator-side types of the core monitor
// core and LP indices, timestamps, per-core masks

`include "monitor_config.svh"

package sim_types_pkg;

   // index widths follow the configured counts
   localparam int CORE_ID_WID = $clog2(`MON_NUM_CORE);
   localparam int LP_ID_WID = $clog2(`MON_NUM_LP);

   // which core
   typedef logic [CORE_ID_WID-1:0] core_id_t;
   // which logical process
   typedef logic [LP_ID_WID-1:0] lp_id_t;
   // event timestamp
   typedef logic [`MON_TIME_WID-1:0] event_time_t;
   // one bit per core, bit n is core n
   typedef logic [`MON_NUM_CORE-1:0] core_mask_t;

endpackage

// ==== design/monitor_config.svh ====
// build-time sizes of the core monitor
// core count, LP count, timestamp and bus widths

`ifndef MONITOR_CONFIG_SVH
`define MONITOR_CONFIG_SVH

// number of cores, must be a power of two
`define MON_NUM_CORE 4
// number of logical processes
`define MON_NUM_LP 8
`define MON_TIME_WID 16
`define MON_MSG_WID 32

`endif
